// ==== source/mpf_req_pkg.sv ====
/*
 * Memory shim request definitions. Widths, request structs and the
 * default buffer sizing shared by the request path
 */

`default_nettype none

package mpf_req_pkg;

    // ==================================================
    // Field widths
    // ==================================================

    // Byte address of a request
    parameter int ADDR_BITS = 32;
    // Running tag, wraps modulo 256
    parameter int TAG_BITS = 8;
    // Write payload
    parameter int DATA_BITS = 64;

    typedef logic [ADDR_BITS-1:0] t_req_addr;
    typedef logic [TAG_BITS-1:0]  t_req_tag;
    typedef logic [DATA_BITS-1:0] t_req_data;

    // ==================================================
    // Request formats
    // ==================================================

    // Read request on channel 0, 40 bits
    typedef struct packed {
        t_req_addr addr;
        t_req_tag  tag;
    } t_c0_req;

    // Write request on channel 1, 104 bits
    typedef struct packed {
        t_req_addr addr;
        t_req_tag  tag;
        t_req_data data;
    } t_c1_req;

    // Almost full rises with this many free slots or fewer
    parameter int DEFAULT_THRESHOLD = 2;
    // Slots in each request FIFO
    parameter int DEFAULT_N_ENTRIES = 8;

endpackage

`default_nettype wire

// ==== source/req_fifo.sv ====
/*
 * Request FIFO. Circular buffer over any entry type with an almost-full
 * level taken from the free slots and an optional empty-FIFO bypass
 */

`default_nettype none

module req_fifo
#(
    parameter type T_ENTRY       = logic,
    parameter int  N_ENTRIES     = mpf_req_pkg::DEFAULT_N_ENTRIES,
    parameter int  THRESHOLD     = mpf_req_pkg::DEFAULT_THRESHOLD,
    parameter bit  ENABLE_BYPASS = 1'b0
)
(
    input  wire logic   clk,
    input  wire logic   reset,

    input  wire logic   enq_en,
    input  wire T_ENTRY enq_data,

    input  wire logic   deq_en,
    output T_ENTRY      first,
    output logic        not_empty,

    output logic        almost_full
);

    localparam int PTR_W = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    localparam int CNT_W = $clog2(N_ENTRIES + 1);

    // Storage, the slot at rd_ptr is the head
    T_ENTRY mem [N_ENTRIES];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] free_entries;

    logic empty;
    logic full;
    logic bypass_hit;
    logic store_en;
    logic take_en;

    // Pointers step around the ring, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        ptr_inc = (ptr == PTR_W'(N_ENTRIES - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(N_ENTRIES));

    // An entry arriving at an empty FIFO and consumed in the same cycle
    // never touches the storage when bypass is on
    assign bypass_hit = ENABLE_BYPASS && empty && enq_en && deq_en;
    assign store_en   = enq_en && !bypass_hit;
    assign take_en    = deq_en && !empty;

    // The incoming entry counts as a head only on the bypass path
    assign not_empty = !empty || (ENABLE_BYPASS && enq_en);

    always_comb
    begin
        if (ENABLE_BYPASS && empty)
        begin
            first = enq_data;
        end
        else
        begin
            first = mem[rd_ptr];
        end
    end

    // Almost full depends on registered state only, so there is no
    // combinational path from the dequeue side back to the producer
    assign free_entries = CNT_W'(N_ENTRIES) - count;
    assign almost_full  = (free_entries <= CNT_W'(THRESHOLD));

    always_ff @(posedge clk)
    begin
        if (store_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (store_en)
                wr_ptr <= ptr_inc(wr_ptr);
            if (take_en)
                rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CNT_W'(store_en) - CNT_W'(take_en);
        end
    end

    // A full FIFO accepts a new entry only while its head leaves
    enq_not_full: assert property (@(posedge clk) disable iff (reset)
        enq_en && full |-> deq_en)
        else $error("req_fifo: enqueue into a full FIFO");

    // Consumers must wait for a stored or bypassed head
    deq_not_empty: assert property (@(posedge clk) disable iff (reset)
        deq_en |-> not_empty)
        else $error("req_fifo: dequeue with no head present");

endmodule

`default_nettype wire

// ==== source/afu_req_tagger.sv ====
/*
 * Request tagger. Registers the accelerator read and write strobes and
 * stamps every accepted request from one shared running tag
 */

`default_nettype none

module afu_req_tagger
(
    input  wire logic                   clk,
    input  wire logic                   reset,

    // Accelerator side, one request per high cycle of a strobe
    input  wire logic                   rd_req,
    input  wire mpf_req_pkg::t_req_addr rd_addr,
    input  wire logic                   wr_req,
    input  wire mpf_req_pkg::t_req_addr wr_addr,
    input  wire mpf_req_pkg::t_req_data wr_data,

    // Tagged requests toward the buffer, valid for one cycle
    output logic                        c0_valid,
    output mpf_req_pkg::t_c0_req        c0_req,
    output logic                        c1_valid,
    output mpf_req_pkg::t_c1_req        c1_req
);

    // Next tag to hand out, shared by both channels
    mpf_req_pkg::t_req_tag tag_cnt;

    // ==================================================
    // Tag counter
    // ==================================================

    // Reads take the current value and writes the one after, so the
    // counter moves by the number of strobes seen this cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tag_cnt  <= '0;
            c0_valid <= 1'b0;
            c1_valid <= 1'b0;
        end
        else
        begin
            tag_cnt  <= tag_cnt + mpf_req_pkg::t_req_tag'(rd_req)
                                + mpf_req_pkg::t_req_tag'(wr_req);
            c0_valid <= rd_req;
            c1_valid <= wr_req;
        end
    end

    // ==================================================
    // Payload registers
    // ==================================================

    // Payload is only meaningful alongside its valid, so it loads freely
    always_ff @(posedge clk)
    begin
        c0_req.addr <= rd_addr;
        c0_req.tag  <= tag_cnt;

        // A write sharing the cycle with a read takes the following tag
        c1_req.addr <= wr_addr;
        c1_req.tag  <= tag_cnt + mpf_req_pkg::t_req_tag'(rd_req);
        c1_req.data <= wr_data;
    end

endmodule

`default_nettype wire

// ==== source/afu_req_buffer.sv ====
/*
 * Request buffer shim. Holds reads and writes in separate FIFOs, each with
 * its own almost-full level. Heads leave only on an explicit dequeue
 */

`default_nettype none

module afu_req_buffer
#(
    // Almost full rises with THRESHOLD or fewer free slots
    parameter int N_ENTRIES        = mpf_req_pkg::DEFAULT_N_ENTRIES,
    parameter int THRESHOLD        = mpf_req_pkg::DEFAULT_THRESHOLD,

    // Lets an incoming read skip an empty FIFO when taken at once
    parameter bit ENABLE_C0_BYPASS = 1'b0
)
(
    input  wire logic                 clk,
    input  wire logic                 reset,

    // Tagged requests from the producer
    input  wire logic                 c0_valid,
    input  wire mpf_req_pkg::t_c0_req c0_req,
    input  wire logic                 c1_valid,
    input  wire mpf_req_pkg::t_c1_req c1_req,

    // Explicit dequeue of each head by the consumer
    input  wire logic                 c0_deq,
    input  wire logic                 c1_deq,

    output logic                      c0_head_valid,
    output mpf_req_pkg::t_c0_req      c0_head,
    output logic                      c1_head_valid,
    output mpf_req_pkg::t_c1_req      c1_head,

    // Back-pressure toward the accelerator, from registered counts only
    output logic                      c0_almost_full,
    output logic                      c1_almost_full
);

    // ==================================================
    // Channel 0, reads
    // ==================================================

    // With bypass on, a read arriving at an empty FIFO is offered as the
    // head in the same cycle. If the arbiter takes it right away it is
    // never written, otherwise it lands in the FIFO as usual
    req_fifo
    #(
        .T_ENTRY       (mpf_req_pkg::t_c0_req),
        .N_ENTRIES     (N_ENTRIES),
        .THRESHOLD     (THRESHOLD),
        .ENABLE_BYPASS (ENABLE_C0_BYPASS)
    )
    c0_fifo
    (
        .clk         (clk),
        .reset       (reset),
        .enq_en      (c0_valid),
        .enq_data    (c0_req),
        .deq_en      (c0_deq),
        .first       (c0_head),
        .not_empty   (c0_head_valid),
        .almost_full (c0_almost_full)
    );

    // ==================================================
    // Channel 1, writes
    // ==================================================

    // Writes always go through storage. They are less sensitive to latency
    // and a bypass mux on the wide data would cost more than it returns
    req_fifo
    #(
        .T_ENTRY       (mpf_req_pkg::t_c1_req),
        .N_ENTRIES     (N_ENTRIES),
        .THRESHOLD     (THRESHOLD),
        .ENABLE_BYPASS (1'b0)
    )
    c1_fifo
    (
        .clk         (clk),
        .reset       (reset),
        .enq_en      (c1_valid),
        .enq_data    (c1_req),
        .deq_en      (c1_deq),
        .first       (c1_head),
        .not_empty   (c1_head_valid),
        .almost_full (c1_almost_full)
    );

endmodule

`default_nettype wire

// ==== source/afu_req_arbiter.sv ====
/*
 * Request arbiter. Takes the read and write heads round-robin while the
 * memory side is ready and registers one merged request per cycle
 */

`default_nettype none

module afu_req_arbiter
(
    input  wire logic                 clk,
    input  wire logic                 reset,

    // Heads of the two request FIFOs
    input  wire logic                 c0_head_valid,
    input  wire mpf_req_pkg::t_c0_req c0_head,
    input  wire logic                 c1_head_valid,
    input  wire mpf_req_pkg::t_c1_req c1_head,

    // Memory side can take a request this cycle
    input  wire logic                 fiu_ready,

    // Dequeue pulses back to the buffer
    output logic                      c0_deq,
    output logic                      c1_deq,

    // Merged request toward memory
    output logic                      out_valid,
    output logic                      out_is_write,
    output mpf_req_pkg::t_req_addr    out_addr,
    output mpf_req_pkg::t_req_tag     out_tag,
    output mpf_req_pkg::t_req_data    out_data
);

    // Set when the most recent grant went to writes
    logic last_grant_wr;

    // ==================================================
    // Round-robin choice
    // ==================================================

    // A lone head wins outright. With both present the channel that lost
    // last time goes first
    assign c0_deq = fiu_ready && c0_head_valid && (!c1_head_valid || last_grant_wr);
    assign c1_deq = fiu_ready && c1_head_valid && (!c0_head_valid || !last_grant_wr);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Reads get the first turn after reset
            last_grant_wr <= 1'b1;
            out_valid     <= 1'b0;
        end
        else
        begin
            if (c0_deq)
                last_grant_wr <= 1'b0;
            else if (c1_deq)
                last_grant_wr <= 1'b1;
            out_valid <= c0_deq || c1_deq;
        end
    end

    // ==================================================
    // Merged request register
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (c1_deq)
        begin
            out_is_write <= 1'b1;
            out_addr     <= c1_head.addr;
            out_tag      <= c1_head.tag;
            out_data     <= c1_head.data;
        end
        else if (c0_deq)
        begin
            // Reads carry no payload
            out_is_write <= 1'b0;
            out_addr     <= c0_head.addr;
            out_tag      <= c0_head.tag;
            out_data     <= '0;
        end
    end

    // One request per cycle toward memory
    one_deq: assert property (@(posedge clk) disable iff (reset) !(c0_deq && c1_deq))
        else $error("afu_req_arbiter: both channels dequeued in one cycle");

endmodule

`default_nettype wire

// ==== source/afu_req_path.sv ====
/*
 * Request path top level. Tagger feeds the buffer shim and the arbiter
 * drains it toward the memory interface
 */

`default_nettype none

module afu_req_path
#(
    parameter int N_ENTRIES        = mpf_req_pkg::DEFAULT_N_ENTRIES,
    parameter int THRESHOLD        = mpf_req_pkg::DEFAULT_THRESHOLD,
    parameter bit ENABLE_C0_BYPASS = 1'b0
)
(
    input  wire logic                   clk,
    input  wire logic                   reset,

    // Accelerator request strobes
    input  wire logic                   rd_req,
    input  wire mpf_req_pkg::t_req_addr rd_addr,
    input  wire logic                   wr_req,
    input  wire mpf_req_pkg::t_req_addr wr_addr,
    input  wire mpf_req_pkg::t_req_data wr_data,
    input  wire logic                   fiu_ready,

    output logic                        c0_almost_full,
    output logic                        c1_almost_full,

    // Merged request toward memory
    output logic                        out_valid,
    output logic                        out_is_write,
    output mpf_req_pkg::t_req_addr      out_addr,
    output mpf_req_pkg::t_req_tag       out_tag,
    output mpf_req_pkg::t_req_data      out_data
);

    // Tagger to buffer
    logic                 c0_valid;
    mpf_req_pkg::t_c0_req c0_req;
    logic                 c1_valid;
    mpf_req_pkg::t_c1_req c1_req;

    // Buffer to arbiter and dequeue pulses back
    logic                 c0_head_valid;
    mpf_req_pkg::t_c0_req c0_head;
    logic                 c1_head_valid;
    mpf_req_pkg::t_c1_req c1_head;
    logic                 c0_deq;
    logic                 c1_deq;

    afu_req_tagger tagger
    (
        .clk, .reset, .rd_req, .rd_addr, .wr_req, .wr_addr, .wr_data,
        .c0_valid, .c0_req, .c1_valid, .c1_req
    );

    afu_req_buffer
    #(
        .N_ENTRIES        (N_ENTRIES),
        .THRESHOLD        (THRESHOLD),
        .ENABLE_C0_BYPASS (ENABLE_C0_BYPASS)
    )
    buffer
    (
        .clk, .reset, .c0_valid, .c0_req, .c1_valid, .c1_req, .c0_deq, .c1_deq,
        .c0_head_valid, .c0_head, .c1_head_valid, .c1_head,
        .c0_almost_full, .c1_almost_full
    );

    afu_req_arbiter arbiter
    (
        .clk, .reset, .c0_head_valid, .c0_head, .c1_head_valid, .c1_head,
        .fiu_ready, .c0_deq, .c1_deq,
        .out_valid, .out_is_write, .out_addr, .out_tag, .out_data
    );

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
/*
 * Testbench clock and reset. Free running clock, reset held high for
 * the first few rising edges
 */

`default_nettype none

module clock_gen
#(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
)
(
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released on a rising edge so the DUT sees exactly RESET_CYCLES edges in reset
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== bench/afu_req_path_tb.sv ====
/*
 * Testbench for the request path. Drives read and write strobes, predicts
 * tags and per-channel order, and checks merged requests and almost-full
 */

`default_nettype none

module afu_req_path_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_ENTRIES = mpf_req_pkg::DEFAULT_N_ENTRIES;
    localparam int THRESHOLD = mpf_req_pkg::DEFAULT_THRESHOLD;
    localparam int EXP_BITS  = 1 + mpf_req_pkg::ADDR_BITS + mpf_req_pkg::TAG_BITS
                               + mpf_req_pkg::DATA_BITS;

    // Reads may bypass the FIFO while writes always pass through storage
    localparam int RD_MIN_LATENCY = 2;
    localparam int WR_MIN_LATENCY = 3;

    // ==================================================
    // Run length
    // ==================================================

    localparam int IDLE_CYCLES    = 10;
    localparam int SINGLE_CYCLES  = 8 * 5;
    localparam int RANDOM_CYCLES  = 4 + 200;
    localparam int FILL_CYCLES    = 3 * (N_ENTRIES - THRESHOLD);
    localparam int BACKLOG_CYCLES = 10;
    localparam int STIM_CYCLES    = IDLE_CYCLES + SINGLE_CYCLES + RANDOM_CYCLES
                                    + FILL_CYCLES + BACKLOG_CYCLES;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 200;

    logic                   clk;
    logic                   reset;
    logic                   rd_req;
    mpf_req_pkg::t_req_addr rd_addr;
    logic                   wr_req;
    mpf_req_pkg::t_req_addr wr_addr;
    mpf_req_pkg::t_req_data wr_data;
    logic                   fiu_ready;
    logic                   c0_almost_full;
    logic                   c1_almost_full;
    logic                   out_valid;
    logic                   out_is_write;
    mpf_req_pkg::t_req_addr out_addr;
    mpf_req_pkg::t_req_tag  out_tag;
    mpf_req_pkg::t_req_data out_data;

    // Each channel keeps its own queue of expected {is_write, addr, tag, data}
    logic [EXP_BITS-1:0]    exp_rd_q[$];
    logic [EXP_BITS-1:0]    exp_wr_q[$];
    int                     rd_cycle_q[$];
    int                     wr_cycle_q[$];
    // Records the kind of every output to check the arbitration order
    logic                   kind_log[$];

    mpf_req_pkg::t_req_tag  model_tag;
    int                     cycle_cnt;
    int                     checks;
    int                     errors;
    int                     errors_at_start;
    int                     tests_done;
    string                  test_name;

    clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(3)) clocks (.clk(clk), .reset(reset));

    afu_req_path
    #(
        .N_ENTRIES        (N_ENTRIES),
        .THRESHOLD        (THRESHOLD),
        .ENABLE_C0_BYPASS (1'b1)
    )
    UUT
    (
        .clk, .reset, .rd_req, .rd_addr, .wr_req, .wr_addr, .wr_data, .fiu_ready,
        .c0_almost_full, .c1_almost_full,
        .out_valid, .out_is_write, .out_addr, .out_tag, .out_data
    );

    // ==================================================
    // Reference model and checks
    // ==================================================

    // The read takes the shared tag and a same-cycle write the next one, modulo 256
    function automatic void model_request(
        input logic                   rd,
        input mpf_req_pkg::t_req_addr ra,
        input logic                   wr,
        input mpf_req_pkg::t_req_addr wa,
        input mpf_req_pkg::t_req_data wd
    );
        mpf_req_pkg::t_req_tag rd_tag;
        mpf_req_pkg::t_req_tag wr_tag;
        rd_tag = model_tag;
        wr_tag = rd ? model_tag + 8'd1 : model_tag;
        if (rd)
            exp_rd_q.push_back({1'b0, ra, rd_tag, {mpf_req_pkg::DATA_BITS{1'b0}}});
        if (wr)
            exp_wr_q.push_back({1'b1, wa, wr_tag, wd});
        model_tag = model_tag + 8'(rd) + 8'(wr);
    endfunction

    task automatic compare_value(input string name, input logic [EXP_BITS-1:0] expected,
                                 input logic [EXP_BITS-1:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_done++;
        $display("test %s finished with %0d errors", test_name, errors - errors_at_start);
    endtask

    // Called on a falling edge and returns on the next one with the strobes low
    task automatic drive_cycle(input logic rd, input logic wr);
        mpf_req_pkg::t_req_addr ra;
        mpf_req_pkg::t_req_addr wa;
        mpf_req_pkg::t_req_data wd;
        ra      = $urandom;
        wa      = $urandom;
        wd      = {$urandom, $urandom};
        rd_req  = rd;
        rd_addr = ra;
        wr_req  = wr;
        wr_addr = wa;
        wr_data = wd;
        if (rd)
            rd_cycle_q.push_back(cycle_cnt);
        if (wr)
            wr_cycle_q.push_back(cycle_cnt);
        model_request(rd, ra, wr, wa, wd);
        @(negedge clk);
        rd_req = 1'b0;
        wr_req = 1'b0;
    endtask

    // Waits until every predicted request came out and a little longer for strays
    task automatic drain_outputs();
        while (exp_rd_q.size() != 0 || exp_wr_q.size() != 0)
            @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    // Outputs are registered, so the middle of the cycle is a stable sample point
    initial
    begin : compare_outputs
        logic [EXP_BITS-1:0] actual;
        int                  lat;
        forever
        begin
            @(negedge clk);
            if (!reset && out_valid)
            begin
                actual = {out_is_write, out_addr, out_tag, out_data};
                kind_log.push_back(out_is_write);
                if (out_is_write ? exp_wr_q.size() == 0 : exp_rd_q.size() == 0)
                begin
                    errors++;
                    $display("error: %s produced an output with no request pending", test_name);
                end
                else if (out_is_write)
                begin
                    compare_value(test_name, exp_wr_q.pop_front(), actual);
                    lat = cycle_cnt - wr_cycle_q.pop_front();
                    if (lat < WR_MIN_LATENCY)
                    begin
                        errors++;
                        $display("error: %s write came out %0d cycles after its strobe",
                                 test_name, lat);
                    end
                end
                else
                begin
                    compare_value(test_name, exp_rd_q.pop_front(), actual);
                    lat = cycle_cnt - rd_cycle_q.pop_front();
                    if (lat < RD_MIN_LATENCY)
                    begin
                        errors++;
                        $display("error: %s read came out %0d cycles after its strobe",
                                 test_name, lat);
                    end
                end
            end
        end
    end

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ==================================================
    // Stimulus
    // ==================================================

    initial
    begin : stimulus
        int   seed_value;
        int   occupancy;
        int   rd_left;
        int   wr_left;
        logic kind;
        rd_req     = 1'b0;
        rd_addr    = '0;
        wr_req     = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        fiu_ready  = 1'b1;
        model_tag  = '0;
        checks     = 0;
        errors     = 0;
        tests_done = 0;
        test_name  = "reset";
        seed_value = $urandom(32'hf4ea_e085);
        @(negedge clk);
        while (reset)
            @(negedge clk);

        // The DUT stays quiet after reset and the first request must come out with tag 0
        start_test("idle_after_reset");
        repeat (IDLE_CYCLES)
        begin
            @(negedge clk);
            compare_value("idle out_valid", 1'b0, out_valid);
            compare_value("idle c0_almost_full", 1'b0, c0_almost_full);
            compare_value("idle c1_almost_full", 1'b0, c1_almost_full);
        end
        drive_cycle(1'b1, 1'b0);
        drain_outputs();
        finish_test();

        start_test("single_requests");
        for (int i = 0; i < 8; i++)
        begin
            drive_cycle(i % 2 == 0, i % 2 == 1);
            repeat (4) @(negedge clk);
        end
        drain_outputs();
        finish_test();

        // Paired strobes come first and random traffic that honours almost-full follows
        start_test("mixed_traffic");
        repeat (4)
            drive_cycle(!c0_almost_full, !c1_almost_full);
        repeat (RANDOM_CYCLES - 4)
        begin
            fiu_ready = ($urandom % 4) != 0;
            drive_cycle($urandom % 2 && !c0_almost_full, $urandom % 2 && !c1_almost_full);
        end
        fiu_ready = 1'b1;
        drain_outputs();
        finish_test();

        start_test("read_almost_full");
        fiu_ready = 1'b0;
        occupancy = 0;
        repeat (N_ENTRIES - THRESHOLD)
        begin
            drive_cycle(1'b1, 1'b0);
            repeat (2) @(negedge clk);
            occupancy++;
            compare_value("fill c0_almost_full", occupancy >= N_ENTRIES - THRESHOLD,
                          c0_almost_full);
            compare_value("fill c1_almost_full", 1'b0, c1_almost_full);
        end
        fiu_ready = 1'b1;
        drain_outputs();
        compare_value("drained c0_almost_full", 1'b0, c0_almost_full);
        finish_test();

        // A lone write leaves the last grant on writes, so reads lead next
        start_test("backlog_round_robin");
        drive_cycle(1'b0, 1'b1);
        drain_outputs();
        kind_log.delete();
        fiu_ready = 1'b0;
        repeat (3)
            drive_cycle(1'b1, 1'b1);
        repeat (2)
            drive_cycle(1'b1, 1'b0);
        repeat (2) @(negedge clk);
        fiu_ready = 1'b1;
        drain_outputs();
        compare_value("backlog output count", 8, kind_log.size());
        if (kind_log.size() == 8)
        begin
            rd_left = 5;
            wr_left = 3;
            kind    = 1'b1;
            for (int i = 0; i < 8; i++)
            begin
                kind = (rd_left > 0 && (wr_left == 0 || kind)) ? 1'b0 : 1'b1;
                if (kind)
                    wr_left--;
                else
                    rd_left--;
                compare_value("backlog order", kind, kind_log[i]);
            end
        end
        finish_test();

        $display("summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== afu_req_path.f ====
source/mpf_req_pkg.sv
source/req_fifo.sv
source/afu_req_tagger.sv
source/afu_req_buffer.sv
source/afu_req_arbiter.sv
source/afu_req_path.sv
bench/clock_gen.sv
bench/afu_req_path_tb.sv

// ==== Bender.yml ====
package:
  name: afu_req_path

sources:
  # Request path RTL, package first
  - target: rtl
    files:
      - source/mpf_req_pkg.sv
      - source/req_fifo.sv
      - source/afu_req_tagger.sv
      - source/afu_req_buffer.sv
      - source/afu_req_arbiter.sv
      - source/afu_req_path.sv

  # Testbench, top module afu_req_path_tb
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/afu_req_path_tb.sv
